/* Makefile */
# Verilator build, run and lint for the scan converter post-processor

VERILATOR  ?= verilator
TOP        := tb_scanconv
FILELIST   := sources.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall
RUN_ARGS   := +verilator+error+limit+100
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := test passed
FAIL_MSG   := test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/output_timing_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Progressive output timing with H/V counters, sync, DE and active x/y
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module output_timing_gen (
    input  logic                        PCLK_OUT_i,
    input  logic                        rst_i,
    input  scanconv_pkg::h_timing_cfg_t h_cfg_i,
    input  scanconv_pkg::v_timing_cfg_t v_cfg_i,
    output scanconv_pkg::video_timing_t timing_o
);

    scanconv_pkg::hpos_t h_cnt;
    scanconv_pkg::vpos_t v_cnt;
    scanconv_pkg::hpos_t h_act_start;
    scanconv_pkg::hpos_t h_act_end;
    scanconv_pkg::vpos_t v_act_start;
    scanconv_pkg::vpos_t v_act_end;
    logic                h_in_active;
    logic                v_in_active;
    logic                de_next;
    logic                line_start;

    // Active area begins after sync and back porch
    assign h_act_start = scanconv_pkg::hpos_t'(h_cfg_i.h_synclen)
                       + scanconv_pkg::hpos_t'(h_cfg_i.h_backporch);
    assign h_act_end   = h_act_start + h_cfg_i.h_active;
    assign v_act_start = scanconv_pkg::vpos_t'(v_cfg_i.v_synclen)
                       + scanconv_pkg::vpos_t'(v_cfg_i.v_backporch);
    assign v_act_end   = v_act_start + v_cfg_i.v_active;

    assign h_in_active = (h_cnt >= h_act_start) && (h_cnt < h_act_end);
    assign v_in_active = (v_cnt >= v_act_start) && (v_cnt < v_act_end);
    assign de_next     = h_in_active && v_in_active;

    // First active pixel of an active line
    assign line_start  = de_next && (h_cnt == h_act_start);

    always_ff @(posedge PCLK_OUT_i) begin
        if (rst_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_cfg_i.h_total - 1'b1) begin
            h_cnt <= '0;
            // Vertical counter steps on horizontal wrap
            if (v_cnt == v_cfg_i.v_total - 1'b1) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Stage 1 timing register
    always_ff @(posedge PCLK_OUT_i) begin
        if (rst_i) begin
            timing_o.hsync <= 1'b1;
            timing_o.vsync <= 1'b1;
            timing_o.de    <= 1'b0;
            timing_o.xpos  <= '0;
            timing_o.ypos  <= '0;
        end else begin
            timing_o.hsync <= (h_cnt >= scanconv_pkg::hpos_t'(h_cfg_i.h_synclen));
            timing_o.vsync <= (v_cnt >= scanconv_pkg::vpos_t'(v_cfg_i.v_synclen));
            timing_o.de    <= de_next;

            if (de_next && !line_start) begin
                timing_o.xpos <= timing_o.xpos + 1'b1;
            end else begin
                timing_o.xpos <= '0;
            end

            // Line index holds through horizontal blanking
            if (!v_in_active) begin
                timing_o.ypos <= '0;
            end else if (line_start) begin
                if (v_cnt == v_act_start) begin
                    timing_o.ypos <= '0;
                end else begin
                    timing_o.ypos <= timing_o.ypos + 1'b1;
                end
            end
        end
    end

endmodule

/* design/pixel_combiner.sv */
////////////////////////////////////////////////////////////////////////////
// Pixel delay line and output stage with scanline, border mask, test pattern
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scanconv_settings.svh"

module pixel_combiner (
    input  logic                        PCLK_OUT_i,
    input  logic                        rst_i,
    input  scanconv_pkg::rgb_t          pixel_i,
    input  scanconv_pkg::video_timing_t timing_i,
    input  logic                        mask_en_i,
    input  scanconv_pkg::sl_cmd_t       sl_cmd_i,
    input  scanconv_pkg::window_cfg_t   win_cfg_i,
    input  logic                        testpattern_en_i,
    output scanconv_pkg::rgb_t          pixel_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        de_o,
    output scanconv_pkg::hpos_t         xpos_o,
    output scanconv_pkg::vpos_t         ypos_o
);

    scanconv_pkg::rgb_t          pix_dly [`SC_PIPE_LAT-1];
    scanconv_pkg::video_timing_t timing_s2;
    scanconv_pkg::rgb_t          pix_sl;
    scanconv_pkg::rgb_t          mask_pix;
    scanconv_pkg::color_t        mask_lvl;
    scanconv_pkg::color_t        tp_val;

    function automatic scanconv_pkg::color_t sub_sat(input scanconv_pkg::color_t c,
                                                     input scanconv_pkg::color_t t);
        sub_sat = (c > t) ? scanconv_pkg::color_t'(c - t) : '0;
    endfunction

    // Input pixel runs in step with the timing until the output stage
    always_ff @(posedge PCLK_OUT_i) begin
        pix_dly[0] <= pixel_i;
        for (int i = 1; i < `SC_PIPE_LAT - 1; i++) begin
            pix_dly[i] <= pix_dly[i-1];
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        if (rst_i) begin
            timing_s2 <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, xpos: '0, ypos: '0};
        end else begin
            timing_s2 <= timing_i;
        end
    end

    assign pix_sl.r = sl_cmd_i.draw ? sub_sat(pix_dly[`SC_PIPE_LAT-2].r, sl_cmd_i.thold)
                                    : pix_dly[`SC_PIPE_LAT-2].r;
    assign pix_sl.g = sl_cmd_i.draw ? sub_sat(pix_dly[`SC_PIPE_LAT-2].g, sl_cmd_i.thold)
                                    : pix_dly[`SC_PIPE_LAT-2].g;
    assign pix_sl.b = sl_cmd_i.draw ? sub_sat(pix_dly[`SC_PIPE_LAT-2].b, sl_cmd_i.thold)
                                    : pix_dly[`SC_PIPE_LAT-2].b;

    // Brightness nibble fills both halves of an enabled channel
    assign mask_lvl   = {2{win_cfg_i.mask_br}};
    assign mask_pix.r = win_cfg_i.mask_color[2] ? mask_lvl : '0;
    assign mask_pix.g = win_cfg_i.mask_color[1] ? mask_lvl : '0;
    assign mask_pix.b = win_cfg_i.mask_color[0] ? mask_lvl : '0;

    assign tp_val = scanconv_pkg::color_t'(timing_s2.xpos)
                  ^ scanconv_pkg::color_t'(timing_s2.ypos);

    // Stage 3 output registers
    always_ff @(posedge PCLK_OUT_i) begin
        if (rst_i) begin
            pixel_o <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            de_o    <= 1'b0;
            xpos_o  <= '0;
            ypos_o  <= '0;
        end else begin
            if (testpattern_en_i) begin
                pixel_o <= '{r: tp_val, g: tp_val, b: tp_val};
            end else if (mask_en_i) begin
                pixel_o <= mask_pix;
            end else begin
                pixel_o <= pix_sl;
            end
            hsync_o <= timing_s2.hsync;
            vsync_o <= timing_s2.vsync;
            de_o    <= timing_s2.de;
            xpos_o  <= timing_s2.xpos;
            ypos_o  <= timing_s2.ypos;
        end
    end

endmodule

/* design/scanconv_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared vector types and packed config and timing structs
////////////////////////////////////////////////////////////////////////////

`include "scanconv_settings.svh"

package scanconv_pkg;

    typedef logic [`SC_COLOR_W-1:0] color_t;
    typedef logic [`SC_HCNT_W-1:0]  hpos_t;
    typedef logic [`SC_VCNT_W-1:0]  vpos_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    typedef struct packed {
        hpos_t      h_total;
        hpos_t      h_active;
        logic [7:0] h_synclen;
        logic [8:0] h_backporch;
    } h_timing_cfg_t;

    typedef struct packed {
        vpos_t      v_total;
        vpos_t      v_active;
        logic [3:0] v_synclen;
        logic [8:0] v_backporch;
    } v_timing_cfg_t;

    // Mask colour bits select red, green, blue from msb down
    typedef struct packed {
        hpos_t      x_offset;
        hpos_t      x_size;
        vpos_t      y_offset;
        vpos_t      y_size;
        logic [3:0] mask_br;
        logic [2:0] mask_color;
    } window_cfg_t;

    typedef struct packed {
        logic [`SC_SL_ROWS-1:0] row_overlay;
        logic [3:0]             row_str;
        logic [2:0]             row_iv;
        logic [`SC_SL_COLS-1:0] col_overlay;
        logic [3:0]             col_str;
        logic [3:0]             col_iv;
    } scanline_cfg_t;

    typedef struct packed {
        logic  hsync;
        logic  vsync;
        logic  de;
        hpos_t xpos;
        vpos_t ypos;
    } video_timing_t;

    // Thold is the amount subtracted from each channel
    typedef struct packed {
        logic   draw;
        color_t thold;
    } sl_cmd_t;

endpackage

/* design/scanconv_top.sv */
////////////////////////////////////////////////////////////////////////////
// Output post-processor top with timing, window mask, scanlines, combiner
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scanconv_top (
    input  logic                        PCLK_OUT_i,
    input  logic                        rst_i,
    input  scanconv_pkg::rgb_t          pixel_i,
    input  scanconv_pkg::h_timing_cfg_t h_cfg_i,
    input  scanconv_pkg::v_timing_cfg_t v_cfg_i,
    input  scanconv_pkg::window_cfg_t   win_cfg_i,
    input  scanconv_pkg::scanline_cfg_t sl_cfg_i,
    input  logic                        testpattern_en_i,
    output scanconv_pkg::rgb_t          pixel_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        de_o,
    output scanconv_pkg::hpos_t         xpos_o,
    output scanconv_pkg::vpos_t         ypos_o
);

    scanconv_pkg::video_timing_t timing;
    scanconv_pkg::sl_cmd_t       sl_cmd;
    logic                        mask_en;

    output_timing_gen u_timing (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_i      (rst_i),
        .h_cfg_i    (h_cfg_i),
        .v_cfg_i    (v_cfg_i),
        .timing_o   (timing)
    );

    // Mask and scanline decisions run side by side on the same position
    window_mask_gen u_mask (
        .PCLK_OUT_i (PCLK_OUT_i),
        .timing_i   (timing),
        .win_cfg_i  (win_cfg_i),
        .mask_en_o  (mask_en)
    );

    scanline_gen u_scanline (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_i      (rst_i),
        .timing_i   (timing),
        .sl_cfg_i   (sl_cfg_i),
        .sl_cmd_o   (sl_cmd)
    );

    pixel_combiner u_combiner (
        .PCLK_OUT_i       (PCLK_OUT_i),
        .rst_i            (rst_i),
        .pixel_i          (pixel_i),
        .timing_i         (timing),
        .mask_en_i        (mask_en),
        .sl_cmd_i         (sl_cmd),
        .win_cfg_i        (win_cfg_i),
        .testpattern_en_i (testpattern_en_i),
        .pixel_o          (pixel_o),
        .hsync_o          (hsync_o),
        .vsync_o          (vsync_o),
        .de_o             (de_o),
        .xpos_o           (xpos_o),
        .ypos_o           (ypos_o)
    );

endmodule

/* design/scanline_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Row and column scanline pattern counters and per pixel strength
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scanconv_settings.svh"

module scanline_gen (
    input  logic                        PCLK_OUT_i,
    input  logic                        rst_i,
    input  scanconv_pkg::video_timing_t timing_i,
    input  scanconv_pkg::scanline_cfg_t sl_cfg_i,
    output scanconv_pkg::sl_cmd_t       sl_cmd_o
);

    logic [$clog2(`SC_SL_ROWS)-1:0] row_q;
    logic [$clog2(`SC_SL_ROWS)-1:0] row_cur;
    logic [$clog2(`SC_SL_COLS)-1:0] col_q;
    logic [$clog2(`SC_SL_COLS)-1:0] col_cur;
    logic [`SC_SL_ROWS-1:0]         row_sel;
    logic [`SC_SL_COLS-1:0]         col_sel;
    logic                           line_first;
    logic                           row_hit;
    logic                           col_hit;

    assign line_first = timing_i.de && (timing_i.xpos == '0);

    // Pattern position of the current pixel, derived from the last active pixel
    always_comb begin
        row_cur = row_q;
        if (line_first) begin
            if (timing_i.ypos == '0) begin
                row_cur = '0;
            end else if (row_q >= sl_cfg_i.row_iv) begin
                row_cur = '0;
            end else begin
                row_cur = row_q + 1'b1;
            end
        end

        if (line_first) begin
            col_cur = '0;
        end else if (col_q >= sl_cfg_i.col_iv) begin
            col_cur = '0;
        end else begin
            col_cur = col_q + 1'b1;
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        if (rst_i) begin
            row_q <= '0;
            col_q <= '0;
        end else if (timing_i.de) begin
            row_q <= row_cur;
            col_q <= col_cur;
        end
    end

    // Shift keeps positions past the overlay width at zero
    assign row_sel = sl_cfg_i.row_overlay >> row_cur;
    assign col_sel = sl_cfg_i.col_overlay >> col_cur;
    assign row_hit = timing_i.de && row_sel[0];
    assign col_hit = timing_i.de && col_sel[0];

    // Rows take priority over columns
    always_ff @(posedge PCLK_OUT_i) begin
        if (rst_i) begin
            sl_cmd_o.draw  <= 1'b0;
            sl_cmd_o.thold <= '0;
        end else if (row_hit) begin
            sl_cmd_o.draw  <= 1'b1;
            sl_cmd_o.thold <= {sl_cfg_i.row_str, 4'hf};
        end else if (col_hit) begin
            sl_cmd_o.draw  <= 1'b1;
            sl_cmd_o.thold <= {sl_cfg_i.col_str, 4'hf};
        end else begin
            sl_cmd_o.draw  <= 1'b0;
            sl_cmd_o.thold <= '0;
        end
    end

endmodule

/* design/window_mask_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Display window test marking pixels outside the visible rectangle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scanconv_settings.svh"

module window_mask_gen (
    input  logic                        PCLK_OUT_i,
    input  scanconv_pkg::video_timing_t timing_i,
    input  scanconv_pkg::window_cfg_t   win_cfg_i,
    output logic                        mask_en_o
);

    logic [`SC_HCNT_W:0] x_pos_ext;
    logic [`SC_HCNT_W:0] x_end;
    logic [`SC_VCNT_W:0] y_pos_ext;
    logic [`SC_VCNT_W:0] y_end;
    logic                x_inside;
    logic                y_inside;

    // One extra bit so offset plus size cannot wrap
    assign x_pos_ext = {1'b0, timing_i.xpos};
    assign y_pos_ext = {1'b0, timing_i.ypos};
    assign x_end     = {1'b0, win_cfg_i.x_offset} + {1'b0, win_cfg_i.x_size};
    assign y_end     = {1'b0, win_cfg_i.y_offset} + {1'b0, win_cfg_i.y_size};

    // Start edge inclusive, end edge exclusive
    assign x_inside = (x_pos_ext >= {1'b0, win_cfg_i.x_offset}) && (x_pos_ext < x_end);
    assign y_inside = (y_pos_ext >= {1'b0, win_cfg_i.y_offset}) && (y_pos_ext < y_end);

    // Stage 2 result, lines up with the scanline command
    always_ff @(posedge PCLK_OUT_i) begin
        mask_en_o <= !(x_inside && y_inside);
    end

endmodule

/* include/scanconv_settings.svh */
////////////////////////////////////////////////////////////////////////////
// Widths and pipeline latency for the scan converter output post-processor
////////////////////////////////////////////////////////////////////////////

`ifndef SCANCONV_SETTINGS_SVH
`define SCANCONV_SETTINGS_SVH

// Colour channel width
`define SC_COLOR_W   8

// Horizontal and vertical counter widths
`define SC_HCNT_W    12
`define SC_VCNT_W    11

// Cycles from pixel input sample to pixel output
`define SC_PIPE_LAT  3

// Longest row and column scanline pattern periods
`define SC_SL_ROWS   6
`define SC_SL_COLS   10

`endif

/* sources.f */
+incdir+include
design/scanconv_pkg.sv
design/output_timing_gen.sv
design/window_mask_gen.sv
design/scanline_gen.sv
design/pixel_combiner.sv
design/scanconv_top.sv
test/scanconv_props.sv
test/tb_scanconv.sv

/* test/scanconv_props.sv */
////////////////////////////////////////////////////////////////////////////
// Bound checks on sync shape, position, pixel path, border mask, test pattern
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scanconv_settings.svh"

module scanconv_props (
    input logic                        PCLK_OUT_i,
    input logic                        rst_i,
    input scanconv_pkg::rgb_t          pixel_i,
    input scanconv_pkg::h_timing_cfg_t h_cfg_i,
    input scanconv_pkg::v_timing_cfg_t v_cfg_i,
    input scanconv_pkg::window_cfg_t   win_cfg_i,
    input scanconv_pkg::scanline_cfg_t sl_cfg_i,
    input logic                        testpattern_en_i,
    input scanconv_pkg::rgb_t          pixel_o,
    input logic                        hsync_o,
    input logic                        vsync_o,
    input logic                        de_o,
    input scanconv_pkg::hpos_t         xpos_o,
    input scanconv_pkg::vpos_t         ypos_o
);

    int unsigned              err_cnt = 0;
    scanconv_pkg::rgb_t [2:0] pix_dly;
    logic                     hs_q;
    logic                     vs_q;
    logic                     de_q;
    logic                     hs_seen;
    logic                     frame_new;
    logic [15:0]              hs_low_len;
    logic [15:0]              vs_low_len;
    logic [15:0]              hs_since;
    logic [15:0]              de_len;
    scanconv_pkg::hpos_t      xpos_q;
    scanconv_pkg::vpos_t      last_y;
    scanconv_pkg::hpos_t      x_exp;
    scanconv_pkg::vpos_t      y_exp;
    logic                     inside_win;
    int                       row_idx;
    int                       col_idx;
    scanconv_pkg::color_t     thold;
    scanconv_pkg::rgb_t       line_exp;
    scanconv_pkg::rgb_t       mask_exp;
    scanconv_pkg::color_t     tp_exp;

    task automatic flag_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        err_cnt++;
        $error("mismatch %s got %h expected %h", sig, got, exp);
    endtask

    // Input pixel as it was three edges ago
    always_ff @(posedge PCLK_OUT_i) begin
        pix_dly <= {pix_dly[1:0], pixel_i};
    end

    always_ff @(posedge PCLK_OUT_i) begin
        if (rst_i) begin
            hs_q       <= 1'b1;
            vs_q       <= 1'b1;
            de_q       <= 1'b0;
            hs_seen    <= 1'b0;
            frame_new  <= 1'b1;
            hs_low_len <= '0;
            vs_low_len <= '0;
            hs_since   <= '0;
            de_len     <= '0;
            xpos_q     <= '0;
            last_y     <= '0;
        end else begin
            hs_q       <= hsync_o;
            vs_q       <= vsync_o;
            de_q       <= de_o;
            xpos_q     <= xpos_o;
            hs_low_len <= hsync_o ? '0 : hs_low_len + 16'd1;
            vs_low_len <= vsync_o ? '0 : vs_low_len + 16'd1;
            de_len     <= de_o ? de_len + 16'd1 : '0;
            // Period counter restarts on each hsync falling edge
            if (!hsync_o && hs_q) begin
                hs_seen  <= 1'b1;
                hs_since <= 16'd1;
            end else begin
                hs_since <= hs_since + 16'd1;
            end
            if (de_o) begin
                last_y <= ypos_o;
            end
            if (!vsync_o) begin
                frame_new <= 1'b1;
            end else if (de_o) begin
                frame_new <= 1'b0;
            end
        end
    end

    always_comb begin
        x_exp = de_q ? xpos_q + scanconv_pkg::hpos_t'(1) : '0;
        y_exp = de_q ? last_y : (frame_new ? '0 : last_y + scanconv_pkg::vpos_t'(1));
        inside_win = (xpos_o >= win_cfg_i.x_offset)
                  && (13'(xpos_o) < 13'(win_cfg_i.x_offset) + 13'(win_cfg_i.x_size))
                  && (ypos_o >= win_cfg_i.y_offset)
                  && (12'(ypos_o) < 12'(win_cfg_i.y_offset) + 12'(win_cfg_i.y_size));
        // Row pattern wins over the column pattern
        row_idx = int'(ypos_o) % (int'(sl_cfg_i.row_iv) + 1);
        col_idx = int'(xpos_o) % (int'(sl_cfg_i.col_iv) + 1);
        if (row_idx < `SC_SL_ROWS && sl_cfg_i.row_overlay[row_idx]) begin
            thold = 8'(sl_cfg_i.row_str) * 8'd16 + 8'd15;
        end else if (col_idx < `SC_SL_COLS && sl_cfg_i.col_overlay[col_idx]) begin
            thold = 8'(sl_cfg_i.col_str) * 8'd16 + 8'd15;
        end else begin
            thold = '0;
        end
        line_exp.r = (pix_dly[2].r > thold) ? pix_dly[2].r - thold : '0;
        line_exp.g = (pix_dly[2].g > thold) ? pix_dly[2].g - thold : '0;
        line_exp.b = (pix_dly[2].b > thold) ? pix_dly[2].b - thold : '0;
        mask_exp.r = win_cfg_i.mask_color[2] ? 8'(win_cfg_i.mask_br) * 8'd17 : '0;
        mask_exp.g = win_cfg_i.mask_color[1] ? 8'(win_cfg_i.mask_br) * 8'd17 : '0;
        mask_exp.b = win_cfg_i.mask_color[0] ? 8'(win_cfg_i.mask_br) * 8'd17 : '0;
        tp_exp = xpos_o[7:0] ^ ypos_o[7:0];
    end

    a_hsync_low: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        (hsync_o && !hs_q) |-> (hs_low_len == 16'(h_cfg_i.h_synclen)))
        else flag_mismatch("hsync_o low cycles", $sampled(hs_low_len), 32'(h_cfg_i.h_synclen));
    a_hsync_period: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        (!hsync_o && hs_q && hs_seen) |-> (hs_since == 16'(h_cfg_i.h_total)))
        else flag_mismatch("hsync_o period", $sampled(hs_since), 32'(h_cfg_i.h_total));
    // Vsync low spans whole lines
    a_vsync_low: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        (vsync_o && !vs_q)
        |-> (vs_low_len == 16'(v_cfg_i.v_synclen) * 16'(h_cfg_i.h_total)))
        else flag_mismatch("vsync_o low cycles", $sampled(vs_low_len),
                           32'(v_cfg_i.v_synclen) * 32'(h_cfg_i.h_total));
    a_de_len: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        (!de_o && de_q) |-> (de_len == 16'(h_cfg_i.h_active)))
        else flag_mismatch("de_o high cycles", $sampled(de_len), 32'(h_cfg_i.h_active));
    a_xpos: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        de_o |-> (xpos_o == x_exp))
        else flag_mismatch("xpos_o", $sampled(xpos_o), $sampled(x_exp));
    a_ypos: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        de_o |-> (ypos_o == y_exp))
        else flag_mismatch("ypos_o", $sampled(ypos_o), $sampled(y_exp));
    // Pass-through is the same rule with nothing subtracted
    a_pixel_path: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        (de_o && !testpattern_en_i && inside_win) |-> (pixel_o == line_exp))
        else flag_mismatch("pixel_o", $sampled(pixel_o), $sampled(line_exp));
    a_mask: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        (de_o && !testpattern_en_i && !inside_win) |-> (pixel_o == mask_exp))
        else flag_mismatch("pixel_o mask", $sampled(pixel_o), $sampled(mask_exp));
    a_testpattern: assert property (@(posedge PCLK_OUT_i) disable iff (rst_i)
        (de_o && testpattern_en_i) |-> (pixel_o == {3{tp_exp}}))
        else flag_mismatch("pixel_o pattern", $sampled(pixel_o), {3{$sampled(tp_exp)}});

endmodule

bind scanconv_top scanconv_props u_props (.*);

/* test/tb_scanconv.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench with clock, reset, four config phases, random pixels, watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_scanconv;

    localparam int CLK_PERIOD = 100;
    localparam int H_TOTAL    = 40;
    localparam int V_TOTAL    = 20;
    localparam int PHASES     = 4;
    // Two frames per phase plus two frames of slack for reset and alignment
    localparam int WATCHDOG_CYCLES = (PHASES * 2 + 2) * H_TOTAL * V_TOTAL;

    localparam scanconv_pkg::window_cfg_t FULL_WIN = '{
        x_offset: 12'd0, x_size: 12'd24, y_offset: 11'd0, y_size: 11'd12,
        mask_br: 4'h8, mask_color: 3'b101
    };
    localparam scanconv_pkg::window_cfg_t SMALL_WIN = '{
        x_offset: 12'd5, x_size: 12'd10, y_offset: 11'd3, y_size: 11'd5,
        mask_br: 4'ha, mask_color: 3'b110
    };
    localparam scanconv_pkg::scanline_cfg_t SL_ON = '{
        row_overlay: 6'b000100, row_str: 4'h6, row_iv: 3'd2,
        col_overlay: 10'b0000000011, col_str: 4'h3, col_iv: 4'd4
    };

    logic                        PCLK_OUT_i;
    logic                        rst_i;
    scanconv_pkg::rgb_t          pixel_i;
    scanconv_pkg::h_timing_cfg_t h_cfg_i;
    scanconv_pkg::v_timing_cfg_t v_cfg_i;
    scanconv_pkg::window_cfg_t   win_cfg_i;
    scanconv_pkg::scanline_cfg_t sl_cfg_i;
    logic                        testpattern_en_i;
    scanconv_pkg::rgb_t          pixel_o;
    logic                        hsync_o;
    logic                        vsync_o;
    logic                        de_o;
    scanconv_pkg::hpos_t         xpos_o;
    scanconv_pkg::vpos_t         ypos_o;
    integer                      seed;

    scanconv_top dut (.*);

    // Returns on the edge that samples a falling vsync_o
    task automatic wait_frames(input int count);
        repeat (count) begin
            @(posedge PCLK_OUT_i);
            while (!vsync_o) @(posedge PCLK_OUT_i);
            while (vsync_o) @(posedge PCLK_OUT_i);
        end
    endtask

    task automatic apply_phase(input int phase);
        win_cfg_i        <= (phase == 2 || phase == 4) ? SMALL_WIN : FULL_WIN;
        sl_cfg_i         <= (phase >= 3) ? SL_ON : '0;
        testpattern_en_i <= (phase == 4);
    endtask

    initial begin
        PCLK_OUT_i = 1'b0;
        forever #(CLK_PERIOD / 2) PCLK_OUT_i = ~PCLK_OUT_i;
    end

    always @(posedge PCLK_OUT_i) begin
        pixel_i <= 24'($random(seed));
    end

    initial begin
        seed             = 37;
        rst_i            = 1'b1;
        pixel_i          = '0;
        h_cfg_i          = '{h_total: 12'd40, h_active: 12'd24, h_synclen: 8'd4,
                             h_backporch: 9'd6};
        v_cfg_i          = '{v_total: 11'd20, v_active: 11'd12, v_synclen: 4'd2,
                             v_backporch: 9'd3};
        win_cfg_i        = FULL_WIN;
        sl_cfg_i         = '0;
        testpattern_en_i = 1'b0;
        repeat (5) @(posedge PCLK_OUT_i);
        rst_i <= 1'b0;
        wait_frames(1);
        // Pass-through, window mask, scanlines, test pattern
        for (int phase = 1; phase <= PHASES; phase++) begin
            apply_phase(phase);
            wait_frames(2);
        end
        if (dut.u_props.err_cnt == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "property checks reported errors");
        end
    end

    initial begin
        wait (dut.u_props.err_cnt != 0);
        $display("test failed");
        $fatal(1, "a property check failed");
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: phases did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule
